// ==== Bender.yml ====
package:
  name: simd_stream

sources:
  - core_pkg.sv
  - stream_pkg.sv
  - simd_ifs.sv
  - wb_host_regs.sv
  - simd_core.sv
  - result_mem.sv
  - agu.sv
  - stream_ctrl.sv
  - simd_stream_top.sv
  - target: simulation
    files:
      - tb_simd_stream.sv

// ==== agu.sv ====
`timescale 1ns/1ps
`default_nettype none

module agu #(
    parameter int W = 3
) (
    input  wire          clk,
    input  wire          rst,
    input  wire [W-1:0]  ini,
    input  wire [W-1:0]  fin,
    input  wire          start,
    input  wire          en,
    output logic [W-1:0] data,
    output logic         last
);

    logic run;

    always_ff @(posedge clk) begin
        if (rst) begin
            data <= ini;
            run  <= 1'b0;
        end else if (start) begin
            data <= ini;
            run  <= 1'b1;
        end else if (en & run) begin
            // stop on the final index, data parks there
            if (data == fin) begin
                run <= 1'b0;
            end else begin
                data <= data + 1'b1;
            end
        end
    end

    // flag only while counting
    assign last = run & (data == fin);

endmodule

`default_nettype wire

// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

    // ==============================
    // instruction set
    // ==============================

    // broadcast opcodes, same for every lane
    typedef enum logic [2:0] {
        OP_NOP     = 3'd0,
        OP_LDI     = 3'd1,
        OP_ADDI    = 3'd2,
        OP_ADDLANE = 3'd3,
        OP_SHL     = 3'd4,
        OP_ST      = 3'd5,
        OP_LAST    = 3'd6
    } opcode_e;

    // imm is zero-extended to the lane width
    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] slot;
        logic [9:0] imm;
    } instr_t;

    localparam int PROG_DEPTH = 16;
    typedef logic [3:0] pc_t;

    // ==============================
    // host register map
    // ==============================

    // word address, 0..15 are program words
    typedef logic [4:0] wb_adr_t;

    localparam wb_adr_t REG_CTRL   = 5'd16;
    localparam wb_adr_t REG_STATUS = 5'd17;

endpackage

`default_nettype wire

// ==== filelist.f ====
core_pkg.sv
stream_pkg.sv
simd_ifs.sv
wb_host_regs.sv
simd_core.sv
result_mem.sv
agu.sv
stream_ctrl.sv
simd_stream_top.sv
tb_simd_stream.sv

// ==== result_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_mem #(
    parameter int NUM_LANES = 4,
    parameter int DATA_W    = stream_pkg::DEFAULT_DATA_W
) (
    input  wire                   clk,
    input  wire                   rst,
    store_if.sink                 st,
    input  wire stream_pkg::slot_idx_t stream_i,
    input  wire                   stream_v,
    output logic [DATA_W-1:0]     dst_data
);
    import stream_pkg::*;

    logic [DATA_W-1:0] slots [NUM_SLOTS];
    logic [DATA_W-1:0] lane_sum;

    // sum of all lanes, carries out of DATA_W are dropped
    always_comb begin
        lane_sum = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            lane_sum = lane_sum + st.st_data[l*DATA_W +: DATA_W];
        end
    end

    // ==============================
    // slot write and clear
    // ==============================

    always_ff @(posedge clk) begin
        if (rst || st.clear) begin
            // every slot back to zero in one clock
            for (int s = 0; s < NUM_SLOTS; s++) begin
                slots[s] <= '0;
            end
        end else if (st.st_en) begin
            slots[st.st_slot] <= lane_sum;
        end
    end

    // stream read, holds while stream_v low
    always_ff @(posedge clk) begin
        if (stream_v) begin
            dst_data <= slots[stream_i];
        end
    end

endmodule

`default_nettype wire

// ==== simd_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module simd_core #(
    parameter int NUM_LANES = 4,
    parameter int DATA_W    = stream_pkg::DEFAULT_DATA_W
) (
    input wire  clk,
    input wire  rst,
    prog_if.seq prog,
    store_if.src st
);
    import core_pkg::*;
    import stream_pkg::*;

    typedef enum logic {S_IDLE, S_RUN} state_e;

    state_e            state;
    pc_t               pc;
    instr_t            ir;
    logic              running;
    logic              start;
    logic [DATA_W-1:0] acc [NUM_LANES];

    // one lane step for the broadcast opcode
    function automatic logic [DATA_W-1:0] lane_next(
        input logic [DATA_W-1:0] acc_in,
        input instr_t            ins,
        input int                lane
    );
        logic [DATA_W-1:0] nxt;
        nxt = acc_in;
        case (ins.opcode)
            OP_LDI:                nxt = DATA_W'(ins.imm);
            OP_ADDI:               nxt = acc_in + DATA_W'(ins.imm);
            OP_ADDLANE:            nxt = acc_in + DATA_W'(lane);
            OP_SHL:                nxt = acc_in << 1;
            OP_NOP, OP_ST, OP_LAST: nxt = acc_in;
            default:               nxt = acc_in;
        endcase
        return nxt;
    endfunction

    assign ir      = prog.instr;
    assign running = (state == S_RUN);
    // go while busy is dropped here
    assign start   = prog.go & ~running;

    // ==============================
    // sequencer
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            pc    <= '0;
        end else if (start) begin
            state <= S_RUN;
            pc    <= '0;
        end else if (running) begin
            pc <= pc + 1'b1;
            if (ir.opcode == OP_LAST) begin
                state <= S_IDLE;
            end
        end
    end

    // lanes in lockstep, zeroed at run start
    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (start) begin
                acc[l] <= '0;
            end else if (running) begin
                acc[l] <= lane_next(acc[l], ir, l);
            end
        end
    end

    assign prog.fetch_pc = pc;
    assign prog.busy     = running;

    // store request and lane completion
    assign st.st_en   = running & (ir.opcode == OP_ST);
    assign st.st_slot = slot_idx_t'(ir.slot);
    assign st.clear   = start;

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            st.st_data[l*DATA_W +: DATA_W] = acc[l];
            st.last[l] = running & (ir.opcode == OP_LAST);
        end
    end

    // last closes the run, busy drops right after
    last_ends_run: assert property (@(posedge clk) disable iff (rst)
        (|st.last) |-> prog.busy ##1 !prog.busy);

endmodule

`default_nettype wire

// ==== simd_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// host regs <-> sequencer
interface prog_if;
    import core_pkg::*;

    logic   go;
    pc_t    fetch_pc;
    instr_t instr;
    logic   busy;

    modport host (output go, output instr, input fetch_pc, input busy);
    modport seq  (input go, input instr, output fetch_pc, output busy);
endinterface

// core stores -> result slots, lane last -> stream control
interface store_if #(
    parameter int NUM_LANES = 4,
    parameter int DATA_W    = stream_pkg::DEFAULT_DATA_W
);
    import stream_pkg::*;

    logic                        st_en;
    slot_idx_t                   st_slot;
    logic [NUM_LANES*DATA_W-1:0] st_data;
    logic                        clear;
    logic [NUM_LANES-1:0]        last;

    modport src   (output st_en, output st_slot, output st_data, output clear, output last);
    modport sink  (input st_en, input st_slot, input st_data, input clear);
    modport watch (input last);
endinterface

`default_nettype wire

// ==== simd_stream_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module simd_stream_top #(
    parameter int NUM_LANES = 4,
    parameter int DATA_W    = stream_pkg::DEFAULT_DATA_W
) (
    input  wire                    clk,
    input  wire                    rst,
    // host wishbone
    input  wire                    wb_cyc,
    input  wire                    wb_stb,
    input  wire                    wb_we,
    input  wire core_pkg::wb_adr_t wb_adr,
    input  wire [15:0]             wb_dat_w,
    output logic [15:0]            wb_dat_r,
    output logic                   wb_ack,
    // result stream
    output logic [DATA_W-1:0]      dst_data,
    output logic                   dst_valid,
    output logic                   dst_last,
    input  wire                    dst_ready
);
    import stream_pkg::*;

    slot_idx_t stream_i;
    logic      stream_v;

    prog_if prog_bus ();
    store_if #(.NUM_LANES(NUM_LANES), .DATA_W(DATA_W)) store_bus ();

    wb_host_regs wb_host_regs_inst (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .prog     (prog_bus.host)
    );

    simd_core #(.NUM_LANES(NUM_LANES), .DATA_W(DATA_W)) simd_core_inst (
        .clk  (clk),
        .rst  (rst),
        .prog (prog_bus.seq),
        .st   (store_bus.src)
    );

    result_mem #(.NUM_LANES(NUM_LANES), .DATA_W(DATA_W)) result_mem_inst (
        .clk      (clk),
        .rst      (rst),
        .st       (store_bus.sink),
        .stream_i (stream_i),
        .stream_v (stream_v),
        .dst_data (dst_data)
    );

    // end-of-index flag is internal to the stream window
    stream_ctrl #(.NUM_LANES(NUM_LANES)) stream_ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .st          (store_bus.watch),
        .dst_ready   (dst_ready),
        .dst_valid   (dst_valid),
        .dst_last    (dst_last),
        .stream_v    (stream_v),
        .stream_i    (stream_i),
        .last_stream ()
    );

endmodule

`default_nettype wire

// ==== stream_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_ctrl #(
    parameter int NUM_LANES = 4
) (
    input  wire                    clk,
    input  wire                    rst,
    store_if.watch                 st,
    input  wire                    dst_ready,
    output logic                   dst_valid,
    output logic                   dst_last,
    output logic                   stream_v,
    output stream_pkg::slot_idx_t  stream_i,
    output logic                   last_stream
);
    import stream_pkg::*;

    logic [NUM_LANES-1:0]     lane_last;
    logic [SETTLE_CYCLES-1:0] last_sr;
    logic                     last_settled;
    logic                     last_keep;
    logic                     stream_ok;
    logic                     stream_active;

    assign lane_last = st.last;

    // ==============================
    // settle delay on lane last
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            last_sr <= '0;
        end else begin
            last_sr <= {last_sr[SETTLE_CYCLES-2:0], |lane_last};
        end
    end

    assign last_settled = last_sr[SETTLE_CYCLES-1];

    // start allowed only with ready high and no stream running
    assign stream_ok = (last_settled | last_keep) & dst_ready & ~stream_active;

    // remember a settled last until it can start
    always_ff @(posedge clk) begin
        if (rst) begin
            last_keep <= 1'b0;
        end else if (stream_ok) begin
            last_keep <= 1'b0;
        end else if (last_settled) begin
            last_keep <= 1'b1;
        end
    end

    // ==============================
    // stream window
    // ==============================

    // high from start until the final index is accepted
    always_ff @(posedge clk) begin
        if (rst) begin
            stream_active <= 1'b0;
        end else if (dst_ready & last_stream) begin
            stream_active <= 1'b0;
        end else if (stream_ok) begin
            stream_active <= 1'b1;
        end
    end

    // slot index walk, steps only on ready
    agu #(
        .W($bits(slot_idx_t))
    ) agu_stream_i (
        .clk   (clk),
        .rst   (rst),
        .ini   (SLOT_FIRST),
        .fin   (SLOT_FINAL),
        .start (stream_ok),
        .en    (dst_ready),
        .data  (stream_i),
        .last  (last_stream)
    );

    // slot read enable for result_mem
    assign stream_v = dst_ready & stream_active;

    // output flags, all frozen while ready low
    always_ff @(posedge clk) begin
        if (rst) begin
            dst_valid <= 1'b0;
            dst_last  <= 1'b0;
        end else if (dst_ready) begin
            dst_valid <= stream_active;
            dst_last  <= stream_active & last_stream;
        end
    end

    last_has_valid: assert property (@(posedge clk) disable iff (rst) dst_last |-> dst_valid);

endmodule

`default_nettype wire

// ==== stream_pkg.sv ====
`default_nettype none

package stream_pkg;

    // result slots, one per stream beat
    localparam int NUM_SLOTS = 8;
    typedef logic [2:0] slot_idx_t;

    // index range walked by the stream agu
    localparam slot_idx_t SLOT_FIRST = 3'd0;
    localparam slot_idx_t SLOT_FINAL = 3'd7;

    // lane accumulator and slot width
    localparam int DEFAULT_DATA_W = 16;

    // lane last goes through this many stages before the stream may start
    // so a store issued next to the closing instruction has landed
    localparam int SETTLE_CYCLES = 2;

endpackage

`default_nettype wire

// ==== tb_simd_stream.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_simd_stream;
    import core_pkg::*;
    import stream_pkg::*;

    localparam int NUM_LANES  = 4;
    localparam int DATA_W     = DEFAULT_DATA_W;
    localparam int CLK_PERIOD = 8;
    localparam int NUM_ROWS   = 5;
    localparam int ROW_CYCLES = 400;
    localparam int SEED       = 55352;
    localparam int PAT_LEN    = 256;

    logic              clk;
    logic              rst;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    wb_adr_t           wb_adr;
    logic [15:0]       wb_dat_w;
    logic [15:0]       wb_dat_r;
    logic              wb_ack;
    logic [DATA_W-1:0] dst_data;
    logic              dst_valid;
    logic              dst_last;
    logic              dst_ready;

    // per row: program, back-pressure mode, go-while-busy flag, slot values
    instr_t            prog_tbl [NUM_ROWS][PROG_DEPTH];
    logic              rand_ready_tbl [NUM_ROWS];
    logic              busy_go_tbl [NUM_ROWS];
    logic [DATA_W-1:0] exp_tbl [NUM_ROWS][NUM_SLOTS];

    logic              ready_pat [PAT_LEN];
    logic              rand_ready;
    int                err_cnt;
    logic [DATA_W-1:0] beat_data [$];
    logic              beat_last [$];

    simd_stream_top #(.NUM_LANES(NUM_LANES), .DATA_W(DATA_W)) simd_stream_top_inst (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .dst_data  (dst_data),
        .dst_valid (dst_valid),
        .dst_last  (dst_last),
        .dst_ready (dst_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==============================
    // back-pressure and beat capture
    // ==============================

    // mode is latched on the edge, ready changes 1 ns later
    initial begin : ready_drive
        int  idx;
        logic use_rand;
        idx = 0;
        forever begin
            @(posedge clk);
            use_rand = rand_ready;
            #1;
            dst_ready = use_rand ? ready_pat[idx] : 1'b1;
            idx = (idx + 1) % PAT_LEN;
        end
    end

    // valid and ready seen here are what the next rising edge takes
    always @(negedge clk) begin
        if (!rst && dst_valid && dst_ready) begin
            beat_data.push_back(dst_data);
            beat_last.push_back(dst_last);
        end
    end

    initial begin
        #((NUM_ROWS * ROW_CYCLES + 10) * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", NUM_ROWS * ROW_CYCLES);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    // ==============================
    // compare tasks
    // ==============================

    task automatic report_error(input string msg);
        err_cnt++;
        $display("Error: %0d ns: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got 0x%0h, expected 0x%0h", what, got, exp));
        end
    endtask

    task automatic check_instr(input instr_t got, input instr_t exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got 0x%04h, expected 0x%04h", what, got, exp));
        end
    endtask

    task automatic check_slot_beat(input logic [DATA_W-1:0] got_data, input logic got_last,
                                   input logic [DATA_W-1:0] exp_data, input logic exp_last,
                                   input int row, input int idx);
        if (got_data !== exp_data || got_last !== exp_last) begin
            report_error($sformatf("row %0d beat %0d: got 0x%0h last %b, expected 0x%0h last %b",
                                   row, idx, got_data, got_last, exp_data, exp_last));
        end
    endtask

    // ==============================
    // wishbone host tasks
    // ==============================

    // entered and left 1 ns after a rising edge
    task automatic wb_access(input logic we, input wb_adr_t adr, input logic [15:0] wdat,
                             output logic [15:0] rdat);
        int n;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!wb_ack && n < 16);
        if (!wb_ack) begin
            report_error($sformatf("no ack for access to word %0d", adr));
        end
        // ack due exactly one clock after the request
        if (n != 1) begin
            report_error($sformatf("ack for word %0d came after %0d clocks", adr, n));
        end
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #1;
        check_bit(wb_ack, 1'b0, "ack lasted more than one cycle");
    endtask

    task automatic wb_write(input wb_adr_t adr, input logic [15:0] dat);
        logic [15:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input wb_adr_t adr, output logic [15:0] dat);
        wb_access(1'b0, adr, 16'd0, dat);
    endtask

    // ==============================
    // table and model
    // ==============================

    function automatic instr_t make_instr(input opcode_e op, input int slot, input int imm);
        instr_t ins;
        ins.opcode = op;
        ins.slot   = 3'(slot);
        ins.imm    = 10'(imm);
        return ins;
    endfunction

    function automatic int rand_imm();
        return int'($urandom % 1024);
    endfunction

    task automatic build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int p = 0; p < PROG_DEPTH; p++) begin
                prog_tbl[r][p] = make_instr(OP_LAST, 0, 0);
            end
            rand_ready_tbl[r] = 1'b0;
            busy_go_tbl[r]    = 1'b0;
        end
        // row 0, all eight slots, always ready
        prog_tbl[0][0]  = make_instr(OP_LDI, 0, 3);
        prog_tbl[0][1]  = make_instr(OP_ST, 0, 0);
        prog_tbl[0][2]  = make_instr(OP_ADDLANE, 0, 0);
        prog_tbl[0][3]  = make_instr(OP_ST, 1, 0);
        prog_tbl[0][4]  = make_instr(OP_ADDI, 0, 100);
        prog_tbl[0][5]  = make_instr(OP_ST, 2, 0);
        prog_tbl[0][6]  = make_instr(OP_SHL, 0, 0);
        prog_tbl[0][7]  = make_instr(OP_ST, 3, 0);
        prog_tbl[0][8]  = make_instr(OP_ADDI, 0, 7);
        prog_tbl[0][9]  = make_instr(OP_ST, 4, 0);
        prog_tbl[0][10] = make_instr(OP_SHL, 0, 0);
        prog_tbl[0][11] = make_instr(OP_ST, 5, 0);
        prog_tbl[0][12] = make_instr(OP_ADDLANE, 0, 0);
        prog_tbl[0][13] = make_instr(OP_ST, 6, 0);
        prog_tbl[0][14] = make_instr(OP_ST, 7, 0);
        // row 1, random immediates under random ready
        prog_tbl[1][0]  = make_instr(OP_LDI, 0, rand_imm());
        prog_tbl[1][1]  = make_instr(OP_ST, 0, 0);
        prog_tbl[1][2]  = make_instr(OP_ADDI, 0, rand_imm());
        prog_tbl[1][3]  = make_instr(OP_ST, 1, 0);
        prog_tbl[1][4]  = make_instr(OP_ADDLANE, 0, 0);
        prog_tbl[1][5]  = make_instr(OP_ST, 2, 0);
        prog_tbl[1][6]  = make_instr(OP_SHL, 0, 0);
        prog_tbl[1][7]  = make_instr(OP_ST, 3, 0);
        prog_tbl[1][8]  = make_instr(OP_ADDI, 0, rand_imm());
        prog_tbl[1][9]  = make_instr(OP_ST, 4, 0);
        prog_tbl[1][10] = make_instr(OP_SHL, 0, 0);
        prog_tbl[1][11] = make_instr(OP_ST, 5, 0);
        prog_tbl[1][12] = make_instr(OP_ADDI, 0, rand_imm());
        prog_tbl[1][13] = make_instr(OP_ST, 6, 0);
        prog_tbl[1][14] = make_instr(OP_ST, 7, 0);
        rand_ready_tbl[1] = 1'b1;
        // row 2, lane values and their sum wrap, slots 1..6 left unstored
        prog_tbl[2][0] = make_instr(OP_LDI, 0, 1023);
        for (int p = 1; p <= 6; p++) begin
            prog_tbl[2][p] = make_instr(OP_SHL, 0, 0);
        end
        prog_tbl[2][7] = make_instr(OP_ST, 0, 0);
        prog_tbl[2][8] = make_instr(OP_SHL, 0, 0);
        prog_tbl[2][9] = make_instr(OP_ST, 7, 0);
        rand_ready_tbl[2] = 1'b1;
        // row 3, long enough for a second go to land mid-run
        prog_tbl[3][0]  = make_instr(OP_LDI, 0, 5);
        prog_tbl[3][1]  = make_instr(OP_ADDLANE, 0, 0);
        prog_tbl[3][2]  = make_instr(OP_ST, 2, 0);
        prog_tbl[3][3]  = make_instr(OP_NOP, 0, 0);
        prog_tbl[3][4]  = make_instr(OP_NOP, 0, 0);
        prog_tbl[3][5]  = make_instr(OP_ADDI, 0, 9);
        prog_tbl[3][6]  = make_instr(OP_ST, 5, 0);
        prog_tbl[3][7]  = make_instr(OP_SHL, 0, 0);
        prog_tbl[3][8]  = make_instr(OP_ST, 1, 0);
        prog_tbl[3][9]  = make_instr(OP_NOP, 0, 0);
        prog_tbl[3][10] = make_instr(OP_ADDLANE, 0, 0);
        prog_tbl[3][11] = make_instr(OP_ST, 6, 0);
        busy_go_tbl[3] = 1'b1;
        // row 4, one store, the rest must come back zero
        prog_tbl[4][0] = make_instr(OP_ADDLANE, 0, 0);
        prog_tbl[4][1] = make_instr(OP_ST, 3, 0);
        rand_ready_tbl[4] = 1'b1;
    endtask

    // expected slots from the opcode rules, slots start at zero each run
    task automatic model_row(input int row);
        logic [DATA_W-1:0] acc [NUM_LANES];
        logic [DATA_W-1:0] sum;
        instr_t            ins;
        int                pc;
        logic              done;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            exp_tbl[row][s] = '0;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            acc[l] = '0;
        end
        pc   = 0;
        done = 1'b0;
        while (!done && pc < PROG_DEPTH) begin
            ins = prog_tbl[row][pc];
            case (ins.opcode)
                OP_LDI: begin
                    for (int l = 0; l < NUM_LANES; l++) acc[l] = DATA_W'(ins.imm);
                end
                OP_ADDI: begin
                    for (int l = 0; l < NUM_LANES; l++) acc[l] = acc[l] + DATA_W'(ins.imm);
                end
                OP_ADDLANE: begin
                    for (int l = 0; l < NUM_LANES; l++) acc[l] = acc[l] + DATA_W'(l);
                end
                OP_SHL: begin
                    for (int l = 0; l < NUM_LANES; l++) acc[l] = {acc[l][DATA_W-2:0], 1'b0};
                end
                OP_ST: begin
                    sum = '0;
                    for (int l = 0; l < NUM_LANES; l++) sum = sum + acc[l];
                    exp_tbl[row][ins.slot] = sum;
                end
                OP_LAST: done = 1'b1;
                default: ;
            endcase
            pc++;
        end
    endtask

    // ==============================
    // main sequence
    // ==============================

    initial begin : main
        logic [15:0] rd;
        int          polls;
        int          waits;
        void'($urandom(SEED));
        err_cnt    = 0;
        rst        = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        dst_ready  = 1'b0;
        rand_ready = 1'b0;
        for (int i = 0; i < PAT_LEN; i++) begin
            ready_pat[i] = 1'($urandom % 2);
        end
        build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            model_row(r);
        end

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_bit(wb_ack, 1'b0, "wb_ack after reset");
        check_bit(dst_valid, 1'b0, "dst_valid after reset");
        check_bit(dst_last, 1'b0, "dst_last after reset");
        wb_read(REG_STATUS, rd);
        check_word(rd, '0, "status after reset");

        for (int r = 0; r < NUM_ROWS; r++) begin
            rand_ready = rand_ready_tbl[r];
            for (int p = 0; p < PROG_DEPTH; p++) begin
                wb_write(wb_adr_t'(p), prog_tbl[r][p]);
            end
            for (int p = 0; p < PROG_DEPTH; p++) begin
                wb_read(wb_adr_t'(p), rd);
                check_instr(instr_t'(rd), prog_tbl[r][p], $sformatf("row %0d word %0d", r, p));
            end
            beat_data.delete();
            beat_last.delete();
            wb_write(REG_CTRL, 16'd1);
            if (busy_go_tbl[r]) begin
                // word 0 already ran, a restart would pick up the new value
                wb_write(wb_adr_t'(0), make_instr(OP_LDI, 0, 999));
                wb_read(REG_STATUS, rd);
                check_bit(rd[0], 1'b1, "status busy during run");
                wb_write(REG_CTRL, 16'd1);
            end

            // run done once busy falls
            polls = 0;
            rd    = 16'd1;
            while (rd[0]) begin
                if (polls >= 64) begin
                    report_error($sformatf("row %0d: the run never finished", r));
                end
                wb_read(REG_STATUS, rd);
                polls++;
            end

            waits = 0;
            while (beat_data.size() < NUM_SLOTS) begin
                if (waits >= 200) begin
                    report_error($sformatf("row %0d: stream stopped after %0d beats",
                                           r, beat_data.size()));
                end
                @(posedge clk);
                #1;
                waits++;
            end
            // room for a duplicated beat or frame to show up
            repeat (16) @(posedge clk);
            #1;
            if (beat_data.size() != NUM_SLOTS) begin
                report_error($sformatf("row %0d: %0d beats in the frame, expected %0d",
                                       r, beat_data.size(), NUM_SLOTS));
            end
            for (int i = 0; i < NUM_SLOTS; i++) begin
                check_slot_beat(beat_data[i], beat_last[i], exp_tbl[r][i],
                                (i == NUM_SLOTS - 1), r, i);
            end
            check_bit(dst_valid, 1'b0, "dst_valid after frame");
        end

        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== wb_host_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_host_regs (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  wb_cyc,
    input  wire                  wb_stb,
    input  wire                  wb_we,
    input  wire core_pkg::wb_adr_t wb_adr,
    input  wire [15:0]           wb_dat_w,
    output logic [15:0]          wb_dat_r,
    output logic                 wb_ack,
    prog_if.host                 prog
);
    import core_pkg::*;

    instr_t prog_mem [PROG_DEPTH];
    logic   req;
    logic   go_q;

    // new request only while no ack is out, gives single cycle ack
    assign req = wb_cyc & wb_stb & ~wb_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            go_q   <= 1'b0;
        end else begin
            wb_ack <= req;
            // go only from a write to ctrl with bit 0 set
            go_q   <= req & wb_we & (wb_adr == REG_CTRL) & wb_dat_w[0];
        end
    end

    // ==============================
    // program memory and read data
    // ==============================

    always_ff @(posedge clk) begin
        // bit 4 clear selects a program word
        if (req & wb_we & ~wb_adr[4]) begin
            prog_mem[pc_t'(wb_adr[3:0])] <= instr_t'(wb_dat_w);
        end
        if (req & ~wb_we) begin
            if (~wb_adr[4]) begin
                wb_dat_r <= prog_mem[pc_t'(wb_adr[3:0])];
            end else if (wb_adr == REG_STATUS) begin
                wb_dat_r <= {15'd0, prog.busy};
            end else begin
                // ctrl and unmapped read as zero
                wb_dat_r <= '0;
            end
        end
    end

    // fetch port, combinational for the sequencer
    assign prog.instr = prog_mem[prog.fetch_pc];
    assign prog.go    = go_q;

    ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack);

endmodule

`default_nettype wire
